//--- vlog.f
src/decode_pkg.sv
src/instr_classifier.sv
src/imm_gen.sv
src/reg_lock_queue.sv
src/hazard_unit.sv
src/operand_issue.sv
src/decode_top.sv
bench/decode_checker.sv
bench/tb_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv -f vlog.f \
    --top-module tb_decode -Mdir obj_dir -o tb_decode

./obj_dir/tb_decode | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

//--- bench/tb_decode.sv
// Decode stage testbench with clock, reset, LFSR stimulus, test sequence and timeout
`timescale 1ns/1ps

module tb_decode;
    import decode_pkg::*;

    localparam int N_ALU = 200;
    localparam int N_DEP = 40;                      // Producer and consumer pairs
    localparam int N_MEM = 30;
    localparam int N_BR  = 100;
    localparam int N_MIX = 200;
    localparam int TEST_CYCLES = 4 + 2 * N_ALU + 3 * N_DEP + 4 * N_MEM + N_BR + 3 * N_MIX;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [4:0]  rs1_o;
    logic [4:0]  rs2_o;
    logic [4:0]  rd_o;
    issue_t      issue_o;
    logic        hazard_o;
    logic        predicted_branch_o;
    logic        predict_taken_o;
    logic [31:0] predict_pc_o;
    int          checks;
    int          errors;
    int          test_no = 1;
    int          errors_before = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h989a_e229;
    logic [31:0] word;
    logic [31:0] sel;
    logic [6:0]  opc;
    logic [4:0]  r;

    always #20 clk = ~clk;

    decode_top uut (.*);

    decode_checker u_checker (
        .clk(clk), .reset(reset), .stall_i(stall_i), .instruction_i(instruction_i),
        .pc_i(pc_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .rs1_i(rs1_o), .rs2_i(rs2_o), .rd_i(rd_o), .issue_i(issue_o), .hazard_i(hazard_o),
        .predicted_branch_i(predicted_branch_o), .predict_taken_i(predict_taken_o),
        .predict_pc_i(predict_pc_o), .checks_o(checks), .errors_o(errors)
    );

    // Taps 32, 22, 2, 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        logic        fb;
        res = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            res  = {res[30:0], fb};
        end
        return res;
    endfunction

    function automatic logic [4:0] hi_reg();
        logic [31:0] b;
        b = rand_bits(4);
        return {1'b1, b[3:0]};                      // x16..x31 for destinations
    endfunction

    function automatic logic [4:0] lo_reg();
        logic [31:0] b;
        b = rand_bits(4);
        return {1'b0, b[3:0]};
    endfunction

    // Random funct and immediate bits around fixed register fields
    function automatic logic [31:0] compose(input logic [6:0] op_code, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] w;
        w = rand_bits(32);
        case (op_code)
            OPC_OP:     w[31:25] = (rand_bits(2) == 0) ? 7'h20 : 7'h00;
            OPC_OP_IMM: if (w[13:12] == 2'b01) w[31:25] = (rand_bits(2) == 0) ? 7'h20 : 7'h00;
            OPC_JALR:   w[14:12] = 3'd0;
            OPC_BRANCH: if (w[14:13] == 2'b01) w[14] = 1'b1;
            OPC_LOAD:   if (w[13:12] == 2'b11 || w[14:13] == 2'b11) w[13] = 1'b0;
            OPC_STORE: begin
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) w[13] = 1'b0;
            end
            default: ;
        endcase
        w[6:0]   = op_code;
        w[11:7]  = rd;
        w[19:15] = rs1;
        w[24:20] = rs2;
        return w;
    endfunction

    // Holds the word until the stage takes it
    task automatic present(input logic [31:0] instr, input int stall_weight);
        logic accepted;
        instruction_i = instr;
        accepted      = 1'b0;
        while (!accepted) begin
            stall_i    = (rand_bits(4) < 32'(stall_weight));
            rs1_data_i = rand_bits(32);
            rs2_data_i = rand_bits(32);
            @(negedge clk);
            accepted = !hazard_o && !stall_i;
            @(posedge clk);
            #2;
        end
        pc_i = pc_i + 32'd4;
    endtask

    task automatic end_test(input string name);
        $display("Test %0d (%s) finished with %0d errors", test_no, name, errors - errors_before);
        test_no++;
        errors_before = errors;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = NOP_WORD;
        pc_i          = 32'h0000_1000;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        present(NOP_WORD, 0);
        end_test("reset values");
        repeat (N_ALU) begin
            sel  = rand_bits(3);
            opc  = (sel < 3) ? OPC_OP : (sel < 5) ? OPC_OP_IMM : (sel == 5) ? OPC_LUI : OPC_AUIPC;
            word = (sel == 7) ? rand_bits(32) : compose(opc, hi_reg(), lo_reg(), lo_reg());
            present(word, 0);
        end
        end_test("independent ALU stream");
        repeat (N_DEP) begin
            r = (rand_bits(3) == 0) ? 5'd0 : hi_reg();  // Sometimes x0
            present(compose(OPC_OP, r, lo_reg(), lo_reg()), 0);
            present(compose(OPC_OP_IMM, hi_reg(), r, lo_reg()), 0);
        end
        end_test("register dependency");
        repeat (N_MEM) begin
            present(compose(OPC_STORE, hi_reg(), lo_reg(), lo_reg()), 0);
            if (rand_bits(2) == 0)
                present(compose(OPC_OP, hi_reg(), lo_reg(), lo_reg()), 0);
            opc = (rand_bits(1) == 0) ? OPC_LOAD : OPC_STORE;
            present(compose(opc, hi_reg(), lo_reg(), lo_reg()), 0);
        end
        end_test("memory after store");
        repeat (N_BR) begin
            sel = rand_bits(2);
            opc = (sel == 0) ? OPC_JAL : (sel == 1) ? OPC_JALR : OPC_BRANCH;
            present(compose(opc, hi_reg(), lo_reg(), lo_reg()), 0);
        end
        end_test("branch prediction");
        repeat (N_MIX) begin
            sel = rand_bits(3);
            opc = (sel == 0) ? OPC_LOAD : (sel == 1) ? OPC_STORE : (sel == 2) ? OPC_BRANCH :
                  (sel == 3) ? OPC_JAL : (sel == 4) ? OPC_LUI : (sel == 5) ? OPC_OP_IMM : OPC_OP;
            present(compose(opc, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5))), 6);
        end
        end_test("random stall");
        instruction_i = NOP_WORD;
        stall_i       = 1'b0;
        repeat (2) @(negedge clk);
        #1;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- bench/decode_checker.sv
// Decode stage reference model with per-cycle comparison of all DUT outputs
`timescale 1ns/1ps

module decode_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  logic [decode_pkg::XLEN-1:0]       instruction_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_i,
    input  decode_pkg::issue_t                issue_i,
    input  logic                              hazard_i,
    input  logic                              predicted_branch_i,
    input  logic                              predict_taken_i,
    input  logic [decode_pkg::XLEN-1:0]       predict_pc_i,
    output int                                checks_o,
    output int                                errors_o
);
    import decode_pkg::*;

    int          n_checks = 0;
    int          n_errors = 0;
    lock_entry_t q0 = '0;                           // Model lock queue
    lock_entry_t q1 = '0;
    logic [31:0] held_word = '0;
    logic        held_hazard = 1'b0;
    issue_t      exp_issue = '0;                    // NOP with zero fields is all zeros
    logic        exp_pred = 1'b0;
    logic [31:0] word;
    op_e         op;
    format_e     fmt;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        hazard;
    logic        taken;

    assign checks_o = n_checks;
    assign errors_o = n_errors;

    function automatic op_e alu_by_f3(input logic [2:0] f3);
        case (f3)
            3'd0:    return ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic op_e ref_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        res;
        f3  = w[14:12];
        f7  = w[31:25];
        res = INVALID;
        case (w[6:0])
            OPC_LUI:   res = LUI;
            OPC_AUIPC: res = ADD;
            OPC_JAL:   res = JAL;
            OPC_JALR:  res = (f3 == 3'd0) ? JALR : INVALID;
            OPC_FENCE: res = (f3 == 3'd0) ? NOP : INVALID;
            OPC_BRANCH: begin
                if (f3 == 3'd0) res = BEQ;
                if (f3 == 3'd1) res = BNE;
                if (f3 == 3'd4) res = BLT;
                if (f3 == 3'd5) res = BGE;
                if (f3 == 3'd6) res = BLTU;
                if (f3 == 3'd7) res = BGEU;
            end
            OPC_LOAD: begin
                if (f3 == 3'd0) res = LB;
                if (f3 == 3'd1) res = LH;
                if (f3 == 3'd2) res = LW;
                if (f3 == 3'd4) res = LBU;
                if (f3 == 3'd5) res = LHU;
            end
            OPC_STORE: begin
                if (f3 == 3'd0) res = SB;
                if (f3 == 3'd1) res = SH;
                if (f3 == 3'd2) res = SW;
            end
            OPC_OP, OPC_OP_IMM: begin
                res = alu_by_f3(f3);
                // Alternate forms only exist for SUB and SRA
                if (f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && w[6:0] == OPC_OP)))
                    res = (f3 == 3'd5) ? SRA : SUB;
                else if (f7 != 7'h00 && (w[6:0] == OPC_OP || f3 == 3'd1 || f3 == 3'd5))
                    res = INVALID;
            end
            default: res = INVALID;                 // SYSTEM and unknown opcodes
        endcase
        if (w == NOP_WORD)
            res = NOP;
        return res;
    endfunction

    function automatic format_e ref_fmt(input logic [31:0] w);
        case (w[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w, input format_e f);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'd0};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Compare, then step the model
    ////////////////////////////////////////

    always @(negedge clk) begin
        word   = held_hazard ? held_word : instruction_i;   // Replay after a bubble
        op     = ref_op(word);
        fmt    = ref_fmt(word);
        imm    = ref_imm(word, fmt);
        rs1    = word[19:15];
        rs2    = word[24:20];
        hazard = ((rs1 != 5'd0) && (rs1 == q0.rd)) || ((rs2 != 5'd0) && (rs2 == q0.rd)) ||
                 ((op inside {LB, LH, LW, LBU, LHU, SB, SH, SW}) &&
                  (q0.is_store || q1.is_store));
        taken  = (op inside {JAL, JALR}) ||
                 ((op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}) && imm[31]);
        if (!reset) begin
            compare("rs1_o", 32'(rs1_i), 32'(rs1));
            compare("rs2_o", 32'(rs2_i), 32'(rs2));
            compare("rd_o", 32'(rd_i), 32'(q1.rd));
            compare("hazard_o", 32'(hazard_i), 32'(hazard));
            compare("predict_taken_o", 32'(predict_taken_i), 32'(taken));
            compare("predict_pc_o", predict_pc_i, pc_i + imm);
            compare("predicted_branch_o", 32'(predicted_branch_i), 32'(exp_pred));
            compare("issue_o.op", 32'(issue_i.op), 32'(exp_issue.op));
            compare("issue_o.first_operand", issue_i.first_operand, exp_issue.first_operand);
            compare("issue_o.second_operand", issue_i.second_operand, exp_issue.second_operand);
            compare("issue_o.third_operand", issue_i.third_operand, exp_issue.third_operand);
            compare("issue_o.pc", issue_i.pc, exp_issue.pc);
            compare("issue_o.exception", 32'(issue_i.exception), 32'(exp_issue.exception));
        end
        held_word   = word;                         // These load even when stalled
        held_hazard = hazard;
        exp_pred    = taken;
        if (reset) begin
            q0        = '0;
            q1        = '0;
            exp_issue = '0;
        end else if (!stall_i) begin
            q1          = q0;
            q0.rd       = hazard ? 5'd0 : word[11:7];
            q0.is_store = !hazard && (op inside {SB, SH, SW});
            if (hazard) begin
                exp_issue = '0;                     // Bubble
            end else begin
                exp_issue.op             = op;
                exp_issue.first_operand  = (fmt == U_TYPE || fmt == J_TYPE) ? pc_i : rs1_data_i;
                exp_issue.second_operand = (fmt == R_TYPE || fmt == B_TYPE) ? rs2_data_i : imm;
                exp_issue.third_operand  = (fmt == S_TYPE) ? rs2_data_i : imm;
                exp_issue.pc             = pc_i;
                exp_issue.exception      = (op == INVALID);
            end
        end
    end

endmodule

//--- src/decode_top.sv
// Decode stage top level connecting classifier, immediate, hazard and issue logic
`timescale 1ns/1ps

module decode_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  logic [decode_pkg::XLEN-1:0]       instruction_i,
    input  logic [decode_pkg::XLEN-1:0]       pc_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output decode_pkg::issue_t                issue_o,
    output logic                              hazard_o,
    output logic                              predicted_branch_o,
    output logic                              predict_taken_o,
    output logic [decode_pkg::XLEN-1:0]       predict_pc_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] instr_w;                       // Fresh or replayed word
    op_e             op;
    format_e         fmt;
    logic [XLEN-1:0] imm;
    lock_entry_t     new_entry;
    lock_entry_t     entry0;
    lock_entry_t     entry1;

    assign rs1_o = instr_w[19:15];                  // Straight to the register file
    assign rs2_o = instr_w[24:20];
    assign rd_o  = entry1.rd;                       // Write-back address

    hazard_unit u_hazard (
        .clk(clk), .instruction_i(instruction_i), .op_i(op),
        .entry0_i(entry0), .entry1_i(entry1),
        .instr_o(instr_w), .entry_o(new_entry), .hazard_o(hazard_o)
    );

    instr_classifier u_classifier (.instr_i(instr_w), .op_o(op), .format_o(fmt));

    imm_gen u_imm (.instr_i(instr_w), .format_i(fmt), .imm_o(imm));

    reg_lock_queue u_lock_queue (
        .clk(clk), .reset(reset), .stall_i(stall_i), .entry_i(new_entry),
        .entry0_o(entry0), .entry1_o(entry1)
    );

    operand_issue u_issue (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard_o),
        .op_i(op), .format_i(fmt), .imm_i(imm), .pc_i(pc_i),
        .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i), .issue_o(issue_o),
        .predicted_branch_o(predicted_branch_o),
        .predict_taken_o(predict_taken_o), .predict_pc_o(predict_pc_o)
    );

endmodule

//--- src/operand_issue.sv
// Operand selection, static branch prediction and the issue output register
`timescale 1ns/1ps

module operand_issue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall_i,
    input  logic                        hazard_i,
    input  decode_pkg::op_e             op_i,
    input  decode_pkg::format_e         format_i,
    input  logic [decode_pkg::XLEN-1:0] imm_i,
    input  logic [decode_pkg::XLEN-1:0] pc_i,
    input  logic [decode_pkg::XLEN-1:0] rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0] rs2_data_i,
    output decode_pkg::issue_t          issue_o,
    output logic                        predicted_branch_o,
    output logic                        predict_taken_o,
    output logic [decode_pkg::XLEN-1:0] predict_pc_o
);
    import decode_pkg::*;

    localparam issue_t BUBBLE = '{
        op:             NOP,
        first_operand:  '0,
        second_operand: '0,
        third_operand:  '0,
        pc:             '0,
        exception:      1'b0
    };

    logic   unconditional;
    logic   conditional;
    issue_t next_issue;

    ////////////////////////////////////////
    // Static branch prediction
    ////////////////////////////////////////

    assign unconditional = (op_i == JAL) || (op_i == JALR);
    assign conditional   = (unit_e'(op_i[5:3]) == BRANCH_UNIT) && !unconditional;

    // Backward branches are usually loops
    assign predict_taken_o = unconditional || (conditional && imm_i[XLEN-1]);
    assign predict_pc_o    = pc_i + imm_i;

    always_ff @(posedge clk) begin
        predicted_branch_o <= predict_taken_o;      // Runs through stalls
    end

    ////////////////////////////////////////
    // Operands and issue register
    ////////////////////////////////////////

    always_comb begin
        next_issue.op = op_i;
        next_issue.first_operand = (format_i == U_TYPE || format_i == J_TYPE) ?
                                   pc_i : rs1_data_i;
        next_issue.second_operand = (format_i == R_TYPE || format_i == B_TYPE) ?
                                    rs2_data_i : imm_i;
        next_issue.third_operand = (format_i == S_TYPE) ? rs2_data_i : imm_i;
        next_issue.pc            = pc_i;
        next_issue.exception     = (op_i == INVALID);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o <= BUBBLE;
        end else if (!stall_i) begin
            if (hazard_i)
                issue_o <= BUBBLE;                  // Word waits for replay
            else
                issue_o <= next_issue;
        end
    end

endmodule

//--- src/hazard_unit.sv
// Hazard unit with replay register, lock entry generation and hazard detection
`timescale 1ns/1ps

module hazard_unit (
    input  logic                        clk,
    input  logic [decode_pkg::XLEN-1:0] instruction_i,
    input  decode_pkg::op_e             op_i,
    input  decode_pkg::lock_entry_t     entry0_i,
    input  decode_pkg::lock_entry_t     entry1_i,
    output logic [decode_pkg::XLEN-1:0] instr_o,
    output decode_pkg::lock_entry_t     entry_o,
    output logic                        hazard_o
);
    import decode_pkg::*;

    logic [XLEN-1:0]       instr_r;             // Word seen last cycle
    logic                  hazard_r;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs1_match;
    logic                  rs2_match;
    logic                  mem_conflict;
    logic                  store_op;

    ////////////////////////////////////////
    // Replay of the held word
    ////////////////////////////////////////

    always_comb begin
        if (hazard_r)
            instr_o = instr_r;                      // Decode it again
        else
            instr_o = instruction_i;
    end

    always_ff @(posedge clk) begin
        instr_r  <= instr_o;
        hazard_r <= hazard_o;
    end

    assign rs1 = instr_o[19:15];
    assign rs2 = instr_o[24:20];

    // Only the youngest lock can still be ahead of the register file write
    assign rs1_match    = (rs1 != '0) && (rs1 == entry0_i.rd);
    assign rs2_match    = (rs2 != '0) && (rs2 == entry0_i.rd);
    assign mem_conflict = (entry0_i.is_store || entry1_i.is_store) &&
                          (unit_e'(op_i[5:3]) == MEMORY_UNIT);
    assign hazard_o     = mem_conflict || rs1_match || rs2_match;

    assign store_op = (op_i == SB) || (op_i == SH) || (op_i == SW);

    always_comb begin
        if (hazard_o) begin
            entry_o = '0;                           // Bubble locks nothing
        end else begin
            entry_o.rd       = instr_o[11:7];
            entry_o.is_store = store_op;
        end
    end

    // A register bubble empties the youngest lock unless execute stalled
    a_bubble_clears_lock: assert property (
        @(posedge clk) (rs1_match || rs2_match) |=> ((entry0_i == '0) || $stable(entry0_i))
    ) else $error("register hazard did not clear the youngest lock");

endmodule

//--- src/reg_lock_queue.sv
// Two-entry lock queue of destinations and store flags of issued instructions
`timescale 1ns/1ps

module reg_lock_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  decode_pkg::lock_entry_t entry_i,
    output decode_pkg::lock_entry_t entry0_o,
    output decode_pkg::lock_entry_t entry1_o
);
    import decode_pkg::*;

    // entry0 is the instruction now in execute, entry1 the one after it
    always_ff @(posedge clk) begin
        if (reset) begin
            entry0_o <= '0;
            entry1_o <= '0;
        end else if (!stall_i) begin
            entry0_o <= entry_i;                    // Newest issue
            entry1_o <= entry0_o;                   // Ages one stage
        end
    end

    // Back-pressure from execute must freeze both locks
    a_stall_holds: assert property (
        @(posedge clk) disable iff (reset)
        (!reset && stall_i) |=> ($stable(entry0_o) && $stable(entry1_o))
    ) else $error("lock queue moved during stall");

endmodule

//--- src/imm_gen.sv
// Immediate generator with sign extension for the I, S, B, U and J formats
`timescale 1ns/1ps

module imm_gen (
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    input  decode_pkg::format_e         format_i,
    output logic [decode_pkg::XLEN-1:0] imm_o
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[31];                      // Always the top bit

    always_comb begin
        case (format_i)
            I_TYPE: begin
                imm_o = {{21{sign}}, instr_i[30:20]};
            end
            S_TYPE: begin
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            end
            B_TYPE: begin
                imm_o = {{20{sign}},
                         instr_i[7],
                         instr_i[30:25],
                         instr_i[11:8],
                         1'b0};                     // Halfword aligned
            end
            U_TYPE: begin
                imm_o = {instr_i[31:12], 12'h000};
            end
            J_TYPE: begin
                imm_o = {{12{sign}},
                         instr_i[19:12],
                         instr_i[20],
                         instr_i[30:25],
                         instr_i[24:21],
                         1'b0};
            end
            default: begin
                imm_o = '0;                         // R format has none
            end
        endcase
    end

endmodule

//--- src/instr_classifier.sv
// Instruction classifier mapping an RV32I word to operation and format
`timescale 1ns/1ps

module instr_classifier (
    input  logic [decode_pkg::XLEN-1:0] instr_i,
    output decode_pkg::op_e             op_o,
    output decode_pkg::format_e         format_o
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Operation
    ////////////////////////////////////////

    always_comb begin
        op_o = INVALID;                             // Anything unmatched
        if (instr_i == NOP_WORD) begin
            op_o = NOP;
        end else begin
            case (opcode)
                OPC_LUI:   op_o = LUI;
                OPC_AUIPC: op_o = ADD;              // pc + imm in the adder
                OPC_JAL:   op_o = JAL;
                OPC_JALR: begin
                    if (funct3 == 3'b000)
                        op_o = JALR;
                end
                OPC_BRANCH: begin
                    case (funct3)
                        3'b000:  op_o = BEQ;
                        3'b001:  op_o = BNE;
                        3'b100:  op_o = BLT;
                        3'b101:  op_o = BGE;
                        3'b110:  op_o = BLTU;
                        3'b111:  op_o = BGEU;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_LOAD: begin
                    case (funct3)
                        3'b000:  op_o = LB;
                        3'b001:  op_o = LH;
                        3'b010:  op_o = LW;
                        3'b100:  op_o = LBU;
                        3'b101:  op_o = LHU;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_STORE: begin
                    case (funct3)
                        3'b000:  op_o = SB;
                        3'b001:  op_o = SH;
                        3'b010:  op_o = SW;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_OP_IMM: begin
                    case (funct3)
                        3'b000:  op_o = ADD;        // ADDI
                        3'b010:  op_o = SLT;
                        3'b011:  op_o = SLTU;
                        3'b100:  op_o = XOR;
                        3'b110:  op_o = OR;
                        3'b111:  op_o = AND;
                        3'b001:  op_o = (funct7 == 7'b0000000) ? SLL : INVALID;
                        default: begin              // SRLI or SRAI
                            if (funct7 == 7'b0000000)
                                op_o = SRL;
                            else if (funct7 == 7'b0100000)
                                op_o = SRA;
                        end
                    endcase
                end
                OPC_OP: begin
                    case ({funct7, funct3})
                        {7'b0000000, 3'b000}: op_o = ADD;
                        {7'b0100000, 3'b000}: op_o = SUB;
                        {7'b0000000, 3'b001}: op_o = SLL;
                        {7'b0000000, 3'b010}: op_o = SLT;
                        {7'b0000000, 3'b011}: op_o = SLTU;
                        {7'b0000000, 3'b100}: op_o = XOR;
                        {7'b0000000, 3'b101}: op_o = SRL;
                        {7'b0100000, 3'b101}: op_o = SRA;
                        {7'b0000000, 3'b110}: op_o = OR;
                        {7'b0000000, 3'b111}: op_o = AND;
                        default:              op_o = INVALID;
                    endcase
                end
                OPC_FENCE: begin
                    if (funct3 == 3'b000)
                        op_o = NOP;                 // Single hart, no reordering
                end
                OPC_SYSTEM: op_o = INVALID;         // No CSR or privileged support
                default:    op_o = INVALID;
            endcase
        end
        if (!$isunknown(instr_i))
            assert (!$isunknown(op_o)) else $error("classifier produced unknown op");
    end

    // Format from the opcode alone
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: format_o = I_TYPE;
            OPC_STORE:                      format_o = S_TYPE;
            OPC_BRANCH:                     format_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             format_o = U_TYPE;
            OPC_JAL:                        format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

endmodule

//--- src/decode_pkg.sv
// Shared widths, RV32I opcodes, operation encodings and decode stage structs
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////
    // Major opcodes, instr[6:0]
    ////////////////////////////////////////

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [2:0] {
        OTHER_UNIT  = 3'b000,                       // Bypass, shifter and invalid
        ALU_UNIT    = 3'b001,
        BRANCH_UNIT = 3'b010,
        MEMORY_UNIT = 3'b011
    } unit_e;

    // Upper octal digit is the execution unit, lower digit picks the op.
    // The ALU digit has room for eight codes only, so the shifter and the
    // LUI bypass share the OTHER unit with NOP and INVALID.
    typedef enum logic [5:0] {
        NOP     = 6'o00,
        LUI     = 6'o01,
        SLL     = 6'o02,
        SRL     = 6'o03,
        SRA     = 6'o04,
        INVALID = 6'o07,
        ADD     = 6'o10,
        SUB     = 6'o11,
        SLT     = 6'o12,
        SLTU    = 6'o13,
        XOR     = 6'o14,
        OR      = 6'o15,
        AND     = 6'o16,
        JAL     = 6'o20,
        JALR    = 6'o21,
        BEQ     = 6'o22,
        BNE     = 6'o23,
        BLT     = 6'o24,
        BGE     = 6'o25,
        BLTU    = 6'o26,
        BGEU    = 6'o27,
        LB      = 6'o30,
        LH      = 6'o31,
        LW      = 6'o32,
        LBU     = 6'o33,
        LHU     = 6'o34,
        SB      = 6'o35,
        SH      = 6'o36,
        SW      = 6'o37
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;                  // Locked destination
        logic                  is_store;            // Pending memory write
    } lock_entry_t;

    typedef struct packed {
        op_e             op;
        logic [XLEN-1:0] first_operand;
        logic [XLEN-1:0] second_operand;
        logic [XLEN-1:0] third_operand;
        logic [XLEN-1:0] pc;
        logic            exception;                 // Invalid encoding
    } issue_t;

endpackage
